// ==== filelist.f ====
+incdir+logic
logic/sample_pkg.sv
logic/filter_ctrl_pkg.sv
logic/window_if.sv
logic/sort3_net.sv
logic/sort5_pipe.sv
logic/sample_window.sv
logic/rank_select.sv
logic/rank_filter_top.sv
testbench/rank_filter_tb.sv

// ==== logic/filter_ctrl_pkg.sv ====
package filter_ctrl_pkg;

  // Order statistic returned by the output stage
  typedef enum logic [2:0] {
    RANK_MIN  = 3'd0,
    RANK_LOW  = 3'd1,
    RANK_MED  = 3'd2,
    RANK_HIGH = 3'd3,
    RANK_MAX  = 3'd4
  } rank_e;

  // Window warm-up
  typedef enum logic {
    FILL = 1'b0,  // Fewer than five samples held
    RUN  = 1'b1   // Every new sample completes a window
  } fill_state_e;

endpackage

// ==== logic/rank_filter_settings.svh ====
`ifndef RANK_FILTER_SETTINGS_SVH
`define RANK_FILTER_SETTINGS_SVH

// Bits per sample, also used for the spread
`define RF_SAMPLE_W    8

// Samples in one sliding window
`define RF_WINDOW_LEN  5

// Register stages between window and sorted output
`define RF_SORT_STAGES 3

`endif

// ==== logic/rank_filter_top.sv ====
`timescale 1ns/100ps

module rank_filter_top import sample_pkg::*, filter_ctrl_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  sample_t sample_i,
  input  logic    sample_valid_i,
  input  logic    flush_i,
  input  rank_e   rank_i,
  output sample_t result_o,
  output spread_t spread_o,
  output logic    result_valid_o
);

  window_if win_bus ();
  sorted_if srt_bus ();

  // Shift window, one strobe per full window
  sample_window u_window (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .flush_i        (flush_i),
    .win            (win_bus.window)
  );

  sort5_pipe u_sort (
    .clk   (clk),
    .rst_n (rst_n),
    .win   (win_bus.sorter),
    .srt   (srt_bus.sorter)
  );

  rank_select u_select (
    .clk            (clk),
    .rst_n          (rst_n),
    .rank_i         (rank_i),
    .srt            (srt_bus.select),
    .result_o       (result_o),
    .spread_o       (spread_o),
    .result_valid_o (result_valid_o)
  );

endmodule

// ==== logic/rank_select.sv ====
`timescale 1ns/100ps

module rank_select import sample_pkg::*, filter_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  rank_e    rank_i,
  sorted_if.select srt,
  output sample_t  result_o,
  output spread_t  spread_o,
  output logic     result_valid_o
);

  sample_t pick;

  always_comb begin
    case (rank_i)
      RANK_MIN:  pick = srt.min_v;
      RANK_LOW:  pick = srt.low_v;
      RANK_MED:  pick = srt.mid_v;
      RANK_HIGH: pick = srt.high_v;
      RANK_MAX:  pick = srt.max_v;
      default:   pick = srt.mid_v;  // Undefined codes give the median
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_o       <= '0;
      spread_o       <= '0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= srt.sort_valid;
      if (srt.sort_valid) begin
        result_o <= pick;
        spread_o <= srt.max_v - srt.min_v;  // Ordered inputs, no wrap
      end
    end
  end

  // Rank must be settled before a sorted window reaches this stage
  a_rank_stable: assert property (@(posedge clk) disable iff (!rst_n)
    srt.sort_valid |-> $stable(rank_i));

endmodule

// ==== logic/sample_pkg.sv ====
`include "rank_filter_settings.svh"

package sample_pkg;

  // One input sample
  typedef logic [`RF_SAMPLE_W-1:0] sample_t;

  // Max minus min of a window, never negative
  typedef logic [`RF_SAMPLE_W-1:0] spread_t;

endpackage

// ==== logic/sample_window.sv ====
`timescale 1ns/100ps
`include "rank_filter_settings.svh"

module sample_window import sample_pkg::*, filter_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  sample_t  sample_i,
  input  logic     sample_valid_i,
  input  logic     flush_i,
  window_if.window win
);

  fill_state_e state;
  logic [$clog2(`RF_WINDOW_LEN + 1)-1:0] fill_cnt;
  sample_t taps [`RF_WINDOW_LEN];  // Index 0 oldest
  logic    win_valid_q;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin  // Flush wins over a sample
      state       <= FILL;
      fill_cnt    <= '0;
      win_valid_q <= 1'b0;
      for (int i = 0; i < `RF_WINDOW_LEN; i++) begin
        taps[i] <= '0;
      end
    end else begin
      win_valid_q <= 1'b0;
      if (sample_valid_i) begin
        for (int i = 0; i < `RF_WINDOW_LEN - 1; i++) begin
          taps[i] <= taps[i+1];
        end
        taps[`RF_WINDOW_LEN-1] <= sample_i;

        case (state)
          FILL: begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == `RF_WINDOW_LEN - 1) begin  // Fifth sample
              state       <= RUN;
              win_valid_q <= 1'b1;
            end
          end
          RUN: win_valid_q <= 1'b1;
        endcase
      end
    end
  end

  assign win.s1        = taps[0];
  assign win.s2        = taps[1];
  assign win.s3        = taps[2];
  assign win.s4        = taps[3];
  assign win.s5        = taps[4];
  assign win.win_valid = win_valid_q;

  a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |=> !win.win_valid);

  a_fill_bound: assert property (@(posedge clk) disable iff (!rst_n)
    fill_cnt <= `RF_WINDOW_LEN);

endmodule

// ==== logic/sort3_net.sv ====
`timescale 1ns/100ps

module sort3_net import sample_pkg::*; (
  input  sample_t a_i,
  input  sample_t b_i,
  input  sample_t c_i,
  output sample_t max_o,
  output sample_t med_o,
  output sample_t min_o
);

  sample_t ab_lo;
  sample_t ab_hi;
  sample_t hc_lo;

  // Exchange a and b
  assign ab_lo = (a_i < b_i) ? a_i : b_i;
  assign ab_hi = (a_i < b_i) ? b_i : a_i;

  // Larger of the pair against c
  assign max_o = (ab_hi < c_i) ? c_i : ab_hi;
  assign hc_lo = (ab_hi < c_i) ? ab_hi : c_i;

  assign med_o = (ab_lo < hc_lo) ? hc_lo : ab_lo;
  assign min_o = (ab_lo < hc_lo) ? ab_lo : hc_lo;

endmodule

// ==== logic/sort5_pipe.sv ====
`timescale 1ns/100ps
`include "rank_filter_settings.svh"

module sort5_pipe import sample_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  window_if.sorter win,
  sorted_if.sorter srt
);

  sample_t sn1_max, sn1_med, sn1_min;
  sample_t sn2_max, sn2_med, sn2_min;
  sample_t sn3_max, sn3_med, sn3_min;

  sample_t p1_s4, p1_s5, p1_max, p1_med, p1_min;
  logic    p1_valid;
  sample_t p2_max, p2_med, p2_min, p2_med1, p2_min1;
  logic    p2_valid;
  sample_t p3_high, p3_med, p3_min, p3_min1, p3_max;
  logic    p3_valid;

  // *******************************************************************
  // Stage 1: three oldest samples
  // *******************************************************************
  sort3_net u_sn1 (
    .a_i   (win.s1),
    .b_i   (win.s2),
    .c_i   (win.s3),
    .max_o (sn1_max),
    .med_o (sn1_med),
    .min_o (sn1_min)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1_s4    <= '0;
      p1_s5    <= '0;
      p1_max   <= '0;
      p1_med   <= '0;
      p1_min   <= '0;
      p1_valid <= 1'b0;
    end else begin
      p1_s4    <= win.s4;
      p1_s5    <= win.s5;
      p1_max   <= sn1_max;
      p1_med   <= sn1_med;
      p1_min   <= sn1_min;
      p1_valid <= win.win_valid;
    end
  end

  // *******************************************************************
  // Stage 2: old max against the two newest, gives global max
  // *******************************************************************
  sort3_net u_sn2 (
    .a_i   (p1_max),
    .b_i   (p1_s4),
    .c_i   (p1_s5),
    .max_o (sn2_max),
    .med_o (sn2_med),
    .min_o (sn2_min)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p2_max   <= '0;
      p2_med   <= '0;
      p2_min   <= '0;
      p2_med1  <= '0;
      p2_min1  <= '0;
      p2_valid <= 1'b0;
    end else begin
      p2_max   <= sn2_max;
      p2_med   <= sn2_med;
      p2_min   <= sn2_min;
      p2_med1  <= p1_med;   // Carried from stage 1
      p2_min1  <= p1_min;
      p2_valid <= p1_valid;
    end
  end

  // *******************************************************************
  // Stage 3: middle candidates, top of them is the fourth rank
  // *******************************************************************
  sort3_net u_sn3 (
    .a_i   (p2_med1),
    .b_i   (p2_med),
    .c_i   (p2_min),
    .max_o (sn3_max),
    .med_o (sn3_med),
    .min_o (sn3_min)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p3_high  <= '0;
      p3_med   <= '0;
      p3_min   <= '0;
      p3_min1  <= '0;
      p3_max   <= '0;
      p3_valid <= 1'b0;
    end else begin
      p3_high  <= sn3_max;
      p3_med   <= sn3_med;
      p3_min   <= sn3_min;
      p3_min1  <= p2_min1;
      p3_max   <= p2_max;
      p3_valid <= p2_valid;
    end
  end

  // Three lowest, combinational after the last register
  sort3_net u_sn4 (
    .a_i   (p3_min1),
    .b_i   (p3_med),
    .c_i   (p3_min),
    .max_o (srt.mid_v),
    .med_o (srt.low_v),
    .min_o (srt.min_v)
  );

  assign srt.high_v     = p3_high;
  assign srt.max_v      = p3_max;
  assign srt.sort_valid = p3_valid;

  a_sort_order: assert property (@(posedge clk) disable iff (!rst_n)
    srt.sort_valid |-> (srt.min_v <= srt.low_v) && (srt.low_v <= srt.mid_v) &&
                       (srt.mid_v <= srt.high_v) && (srt.high_v <= srt.max_v));

  // Fixed latency, one result per window
  a_sort_latency: assert property (@(posedge clk) disable iff (!rst_n)
    srt.sort_valid == $past(win.win_valid, `RF_SORT_STAGES));

endmodule

// ==== logic/window_if.sv ====
`timescale 1ns/100ps

// *********************************************************************
// Five raw window samples, s1 oldest
// *********************************************************************
interface window_if import sample_pkg::*; ();
  sample_t s1;
  sample_t s2;
  sample_t s3;
  sample_t s4;
  sample_t s5;
  logic    win_valid;

  modport window (output s1, s2, s3, s4, s5, win_valid);
  modport sorter (input s1, s2, s3, s4, s5, win_valid);
endinterface

// *********************************************************************
// Five sorted values, min_v lowest
// *********************************************************************
interface sorted_if import sample_pkg::*; ();
  sample_t min_v;
  sample_t low_v;
  sample_t mid_v;
  sample_t high_v;
  sample_t max_v;
  logic    sort_valid;

  modport sorter (output min_v, low_v, mid_v, high_v, max_v, sort_valid);
  modport select (input min_v, low_v, mid_v, high_v, max_v, sort_valid);
endinterface

// ==== testbench/rank_filter_tb.sv ====
`timescale 1ns/100ps
`include "rank_filter_settings.svh"

module rank_filter_tb import sample_pkg::*, filter_ctrl_pkg::*; ();

  typedef sample_t win_t [`RF_WINDOW_LEN];

  logic    clk;
  logic    rst_n;
  sample_t sample_i;
  logic    sample_valid_i;
  logic    flush_i;
  rank_e   rank_i;
  sample_t result_o;
  spread_t spread_o;
  logic    result_valid_o;

  integer seed;
  int     err_cnt;
  int     res_cnt;
  int     test_cnt;
  int     err_mark;
  int     res_mark;

  // Model state, window oldest first
  win_t    mdl_win;
  int      mdl_cnt;
  logic    line_v   [4];
  sample_t line_res [4];
  spread_t line_spr [4];
  logic    exp_valid;
  sample_t exp_result;
  spread_t exp_spread;

  rank_filter_top dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .flush_i        (flush_i),
    .rank_i         (rank_i),
    .result_o       (result_o),
    .spread_o       (spread_o),
    .result_valid_o (result_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Insertion sort, ascending
  function automatic win_t sort_window(input win_t w);
    win_t    s;
    sample_t t;
    s = w;
    for (int i = 1; i < `RF_WINDOW_LEN; i++) begin
      for (int j = i; j > 0 && s[j-1] > s[j]; j--) begin
        t      = s[j];
        s[j]   = s[j-1];
        s[j-1] = t;
      end
    end
    return s;
  endfunction

  // *******************************************************************
  // Reference model, expected output five cycles after the drive edge
  // *******************************************************************
  always @(posedge clk) begin
    win_t s;
    if (!rst_n) begin
      mdl_cnt = 0;
      for (int i = 0; i < 4; i++) begin
        line_v[i] <= 1'b0;
      end
      exp_valid  <= 1'b0;
      exp_result <= '0;
      exp_spread <= '0;
    end else begin
      for (int i = 3; i > 0; i--) begin
        line_v[i]   <= line_v[i-1];
        line_res[i] <= line_res[i-1];
        line_spr[i] <= line_spr[i-1];
      end
      exp_valid <= line_v[3];
      if (line_v[3]) begin
        exp_result <= line_res[3];
        exp_spread <= line_spr[3];
      end
      line_v[0] <= 1'b0;
      if (flush_i) begin
        mdl_cnt = 0;  // Sample in the same cycle is dropped
      end else if (sample_valid_i) begin
        for (int i = 0; i < `RF_WINDOW_LEN - 1; i++) begin
          mdl_win[i] = mdl_win[i+1];
        end
        mdl_win[`RF_WINDOW_LEN-1] = sample_i;
        if (mdl_cnt < `RF_WINDOW_LEN) mdl_cnt++;
        if (mdl_cnt == `RF_WINDOW_LEN) begin
          s = sort_window(mdl_win);
          line_v[0]   <= 1'b1;
          line_res[0] <= s[int'(rank_i)];
          line_spr[0] <= s[`RF_WINDOW_LEN-1] - s[0];
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && result_valid_o) res_cnt++;
  end

  a_valid_match: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_o == exp_valid)
    else begin
      err_cnt++;
      $display("Fail result_valid_o at %0t: expected %h, got %h", $time,
               $sampled(exp_valid), $sampled(result_valid_o));
    end

  a_result_match: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_o |-> result_o == exp_result)
    else begin
      err_cnt++;
      $display("Fail result_o at %0t: expected %h, got %h", $time,
               $sampled(exp_result), $sampled(result_o));
    end

  a_spread_match: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_o |-> spread_o == exp_spread)
    else begin
      err_cnt++;
      $display("Fail spread_o at %0t: expected %h, got %h", $time,
               $sampled(exp_spread), $sampled(spread_o));
    end

  // *******************************************************************
  // Stimulus tasks
  // *******************************************************************
  task automatic push_sample(input sample_t v);
    @(posedge clk);
    sample_i       <= v;
    sample_valid_i <= 1'b1;
    flush_i        <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      sample_valid_i <= 1'b0;
      flush_i        <= 1'b0;
    end
  endtask

  task automatic flush_window();
    @(posedge clk);
    sample_i       <= 8'hAA;  // Must lose against the flush
    sample_valid_i <= 1'b1;
    flush_i        <= 1'b1;
  endtask

  task automatic wait_result();
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      sample_valid_i <= 1'b0;
      flush_i        <= 1'b0;
      if (result_valid_o) begin
        seen = 1'b1;
        break;
      end
    end
    if (!seen) begin
      err_cnt++;
      $display("Timeout: no result appeared after a full window at %0t", $time);
    end
  endtask

  task automatic drain_pipe();
    logic busy;
    busy = 1'b1;
    for (int i = 0; i < 30; i++) begin
      @(posedge clk);
      sample_valid_i <= 1'b0;
      flush_i        <= 1'b0;
      busy = result_valid_o || exp_valid || line_v[0] || line_v[1] ||
             line_v[2] || line_v[3];
      if (i > 0 && !busy) break;  // Model needs one edge to see the last drive
    end
    if (busy) begin
      err_cnt++;
      $display("Timeout: pipeline did not drain at %0t", $time);
    end
  endtask

  task automatic set_rank(input rank_e r);
    drain_pipe();
    @(posedge clk);
    rank_i <= r;
  endtask

  task automatic end_test(input string name);
    drain_pipe();
    test_cnt++;
    $display("Test %s: %0d results, %0d errors", name, res_cnt - res_mark,
             err_cnt - err_mark);
    err_mark = err_cnt;
    res_mark = res_cnt;
  endtask

  // *******************************************************************
  // Test sequence
  // *******************************************************************
  initial begin
    seed           = 39292;
    err_cnt        = 0;
    res_cnt        = 0;
    test_cnt       = 0;
    err_mark       = 0;
    res_mark       = 0;
    rst_n          = 1'b0;
    sample_i       = '0;
    sample_valid_i = 1'b0;
    flush_i        = 1'b0;
    rank_i         = RANK_MED;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < 4; i++) push_sample(sample_t'($random(seed)));
    idle_cycles(8);  // Nothing may come out yet
    push_sample(sample_t'($random(seed)));
    wait_result();
    end_test("warm_up");

    for (int i = 0; i < 200; i++) push_sample(sample_t'($random(seed)));
    end_test("median_stream");

    for (int r = 0; r < 5; r++) begin
      set_rank(rank_e'(r));
      for (int i = 0; i < 30; i++) begin
        case ($random(seed) & 3)
          0:       push_sample(8'h00);
          1:       push_sample(8'hFF);
          2:       push_sample(8'h80);  // Duplicates
          default: push_sample(sample_t'($random(seed)));
        endcase
      end
    end
    end_test("all_ranks");

    set_rank(RANK_MAX);
    for (int i = 0; i < 100; i++) begin
      if (i % 20 < 10) push_sample(8'h40 + (sample_t'($random(seed)) & 8'h07));
      else push_sample(sample_t'($random(seed)));
    end
    end_test("spread");

    set_rank(RANK_MED);
    for (int i = 0; i < 100; i++) begin
      push_sample(sample_t'($random(seed)));
      idle_cycles($unsigned($random(seed)) % 4);
    end
    end_test("gapped_input");

    set_rank(RANK_LOW);
    for (int i = 0; i < 2; i++) push_sample(sample_t'($random(seed)));
    flush_window();
    for (int i = 0; i < 4; i++) push_sample(sample_t'($random(seed)));
    idle_cycles(8);
    push_sample(sample_t'($random(seed)));
    wait_result();
    end_test("flush");

    $display("Tests run: %0d, results checked: %0d, errors: %0d",
             test_cnt, res_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
